/* Makefile */
# Verilator build and run for the USB PHY testbench

VERILATOR ?= verilator
TOP       ?= tb_usb_phy
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* bench/tb_usb_phy.sv */
// ##########################################################################
// Testbench for the USB PHY. Sends random packets at full and low speed
// through a line loopback, plus standalone EOP and bus reset.
// ##########################################################################

`timescale 1ns/1ps

module tb_usb_phy;
	import usb_phy_pkg::*;

	localparam int FS_PKTS = 20;
	localparam int LS_PKTS = 12;
	localparam int NUM_PKTS = FS_PKTS + LS_PKTS + 4;
	localparam int CYCLE_LIMIT = NUM_PKTS * (13 * 9 + 10) * LS_BIT_CLKS * 2;

	logic      usb_clk;
	logic      usb_rst;
	usb_byte_t tx_data;
	logic      tx_valid;
	logic      tx_ready;
	logic      generate_eop;
	logic      generate_reset;
	logic      low_speed;
	logic      txp;
	logic      txm;
	logic      txoe;
	logic      rxp;
	logic      rxm;
	usb_byte_t rx_data;
	logic      rx_valid;
	logic      rx_active;
	logic      rx_error;
	integer    seed;
	int        cycle_cnt = 0;
	usb_byte_t pkt[$];

	// Loopback, idle J of the current speed while not driving
	assign rxp = txoe ? txp : !low_speed;
	assign rxm = txoe ? txm : low_speed;

	usb_phy UUT (.*);

	usb_phy_checker u_checker (.*);

	initial begin
		usb_clk = 1'b0;
		forever #5 usb_clk = ~usb_clk;
	end

	always @(posedge usb_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("Timeout: run hung after %0d cycles", cycle_cnt);
			$display("Test failures found");
			$finish;
		end
	end

	function automatic int bit_clks();
		return low_speed ? LS_BIT_CLKS : FS_BIT_CLKS;
	endfunction

	task automatic apply_reset();
		@(negedge usb_clk);
		usb_rst = 1'b1;
		repeat (16) @(negedge usb_clk);
		usb_rst = 1'b0;
	endtask

	task automatic wait_idle();
		while (txoe)
			@(negedge usb_clk);
		repeat (4 * bit_clks()) @(negedge usb_clk);
	endtask

	task automatic wait_txoe_pulse();
		while (!txoe)
			@(negedge usb_clk);
		while (txoe)
			@(negedge usb_clk);
	endtask

	// Bad first bytes keep bit 0 clear so the receiver starts on it
	task automatic make_packet(input logic bad, input logic biased);
		int len;
		pkt.delete();
		pkt.push_back(bad ? (usb_byte_t'($random(seed)) & 8'h7E) : SYNC_BYTE);
		len = 1 + (($random(seed) & 32'h7fff_ffff) % 12);
		for (int i = 0; i < len; i++) begin
			if (biased && (($random(seed) & 3) != 0))
				pkt.push_back(8'hFF);
			else
				pkt.push_back(usb_byte_t'($random(seed)));
		end
	endtask

	task automatic send_packet();
		@(negedge usb_clk);
		// Skip an idle ready pulse so it is not taken as a transfer
		while (tx_ready)
			@(negedge usb_clk);
		tx_data  = pkt[0];
		tx_valid = 1'b1;
		for (int i = 0; i < pkt.size(); i++) begin
			@(negedge usb_clk);
			while (!tx_ready)
				@(negedge usb_clk);
			@(negedge usb_clk);
			if (i + 1 < pkt.size())
				tx_data = pkt[i + 1];
			else
				tx_valid = 1'b0;
		end
		wait_txoe_pulse();
		wait_idle();
	endtask

	task automatic run_packets(input int count);
		for (int p = 0; p < count; p++) begin
			make_packet((p % 7) == 3, ($random(seed) & 3) == 0);
			send_packet();
		end
	endtask

	task automatic standalone_eop();
		@(negedge usb_clk);
		generate_eop = 1'b1;
		@(negedge usb_clk);
		generate_eop = 1'b0;
		wait_txoe_pulse();
		wait_idle();
	endtask

	task automatic bus_reset(input int bits);
		@(negedge usb_clk);
		generate_reset = 1'b1;
		repeat (bits * bit_clks()) @(negedge usb_clk);
		generate_reset = 1'b0;
		@(negedge usb_clk);
		wait_idle();
	endtask

	initial begin
		seed           = 32'hc97a_1262;
		usb_rst        = 1'b1;
		tx_data        = '0;
		tx_valid       = 1'b0;
		generate_eop   = 1'b0;
		generate_reset = 1'b0;
		low_speed      = 1'b0;
		repeat (16) @(negedge usb_clk);
		usb_rst = 1'b0;
		wait_idle();

		run_packets(FS_PKTS);
		standalone_eop();
		bus_reset(20);

		// Speed change goes through reset so the receiver starts clean
		@(negedge usb_clk);
		low_speed = 1'b1;
		apply_reset();
		wait_idle();
		run_packets(LS_PKTS);
		standalone_eop();
		bus_reset(8);
		repeat (8 * LS_BIT_CLKS) @(negedge usb_clk);

		u_checker.final_checks();
		$display("Errors: %0d mismatches, %0d other failures",
			u_checker.mismatch_count, u_checker.fail_count);
		if ((u_checker.mismatch_count == 0) && (u_checker.fail_count == 0))
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

/* bench/usb_phy_checker.sv */
// ##########################################################################
// Testbench checker for the USB PHY. Watches the DUT ports, models the
// stuffed NRZI line and the received payload, and counts mismatches.
// ##########################################################################

`timescale 1ns/1ps

module usb_phy_checker (
	input logic                   usb_clk,
	input logic                   usb_rst,
	input usb_phy_pkg::usb_byte_t tx_data,
	input logic                   tx_valid,
	input logic                   tx_ready,
	input logic                   generate_eop,
	input logic                   generate_reset,
	input logic                   low_speed,
	input logic                   txp,
	input logic                   txm,
	input logic                   txoe,
	input usb_phy_pkg::usb_byte_t rx_data,
	input logic                   rx_valid,
	input logic                   rx_active,
	input logic                   rx_error
);
	import usb_phy_pkg::*;

	localparam int L_J   = 0;
	localparam int L_K   = 1;
	localparam int L_SE0 = 2;
	localparam int L_SE1 = 3;

	int        mismatch_count = 0;
	int        fail_count = 0;
	int        exp_err = 0;
	usb_byte_t exp_rx[$];
	usb_byte_t pkt_bytes[$];
	usb_byte_t exp_byte;
	int        line_seen[$];
	int        line_exp[$];
	logic      in_pkt;
	logic      pkt_bad;
	logic      reset_mode;
	logic      eop_req;
	logic      active_seen;
	logic      check_active;
	logic      txoe_prev;
	int        ph;
	int        bc;
	int        settle;
	int        idle_cnt;
	int        hold_cnt;

	task automatic report_mismatch(input string msg);
		$display("mismatch at %0t: %s", $time, msg);
		mismatch_count++;
	endtask

	task automatic report_failure(input string msg);
		$display("ERROR at %0t: %s", $time, msg);
		fail_count++;
	endtask

	// Wire pair to line state with J and K swapped at low speed
	function automatic int line_code(input logic p, input logic m, input logic ls);
		if (p && !m)
			return ls ? L_K : L_J;
		if (!p && m)
			return ls ? L_J : L_K;
		if (!p && !m)
			return L_SE0;
		return L_SE1;
	endfunction

	// Model line states for the stuffed NRZI packet and its EOP
	task automatic build_expected();
		int   level;
		int   ones;
		logic b;
		level = L_J;
		ones  = 0;
		line_exp.delete();
		foreach (pkt_bytes[n]) begin
			for (int i = 0; i < 8; i++) begin
				b    = pkt_bytes[n][i];
				ones = b ? ones + 1 : 0;
				if (!b)
					level = (level == L_J) ? L_K : L_J;
				line_exp.push_back(level);
				if (ones == STUFF_RUN) begin
					ones  = 0;
					level = (level == L_J) ? L_K : L_J;
					line_exp.push_back(level);
				end
			end
		end
		line_exp.push_back(L_SE0);
		line_exp.push_back(L_SE0);
		line_exp.push_back(L_J);
	endtask

	task automatic compare_packet();
		int n;
		if (reset_mode) begin
			foreach (line_seen[i])
				if (line_seen[i] != L_SE0)
					report_mismatch($sformatf("bus reset bit %0d line state %0d", i,
						line_seen[i]));
		end else begin
			build_expected();
			if (line_seen.size() != line_exp.size())
				report_mismatch($sformatf("txoe held %0d bit times, expected %0d",
					line_seen.size(), line_exp.size()));
			n = (line_seen.size() < line_exp.size()) ? line_seen.size() : line_exp.size();
			for (int i = 0; i < n; i++)
				if (line_seen[i] != line_exp[i])
					report_mismatch($sformatf("bit %0d line state %0d, expected %0d", i,
						line_seen[i], line_exp[i]));
		end
	endtask

	task automatic final_checks();
		if (exp_err != 0)
			report_failure($sformatf("%0d bad packets gave no rx_error", exp_err));
		if (exp_rx.size() != 0)
			report_failure($sformatf("%0d payload bytes never received", exp_rx.size()));
		if (eop_req)
			report_failure("requested standalone EOP never sent");
	endtask

	always @(posedge usb_clk) begin
		bc = low_speed ? LS_BIT_CLKS : FS_BIT_CLKS;
		if (usb_rst) begin
			txoe_prev    = 1'b0;
			in_pkt       = 1'b0;
			pkt_bad      = 1'b0;
			reset_mode   = 1'b0;
			eop_req      = 1'b0;
			active_seen  = 1'b0;
			check_active = 1'b0;
			ph           = 0;
			settle       = 0;
			idle_cnt     = 0;
			hold_cnt     = 0;
			line_seen.delete();
			pkt_bytes.delete();
		end else begin
			if (generate_eop)
				eop_req = 1'b1;
			// First accepted byte decides between SYNC and a bad packet
			if (tx_valid && tx_ready) begin
				if (!in_pkt) begin
					in_pkt  = 1'b1;
					pkt_bad = (tx_data != SYNC_BYTE);
					if (pkt_bad)
						exp_err++;
				end else if (!pkt_bad) begin
					exp_rx.push_back(tx_data);
				end
				pkt_bytes.push_back(tx_data);
			end
			// Mid-bit samples while txoe is high
			if (txoe) begin
				if (!txoe_prev) begin
					ph          = 0;
					active_seen = 1'b0;
				end else begin
					ph = (ph == bc - 1) ? 0 : ph + 1;
				end
				if (ph == bc / 2)
					line_seen.push_back(line_code(txp, txm, low_speed));
				if (generate_reset)
					reset_mode = 1'b1;
			end else if (txoe_prev) begin
				// An empty packet is a standalone EOP
				if (!reset_mode && (pkt_bytes.size() == 0)) begin
					if (!eop_req)
						report_failure("standalone EOP sent without a request");
					eop_req = 1'b0;
				end
				compare_packet();
				check_active = in_pkt && !pkt_bad;
				settle       = 2 * bc;
				in_pkt       = 1'b0;
				reset_mode   = 1'b0;
				line_seen.delete();
				pkt_bytes.delete();
			end
			if (rx_active)
				active_seen = 1'b1;
			// Receiver must have closed the packet by now
			if (settle > 0) begin
				settle--;
				if (settle == 0) begin
					if (rx_active)
						report_failure("rx_active still high after the EOP");
					if (check_active && !active_seen)
						report_failure("rx_active never rose for a valid packet");
					if (exp_rx.size() != 0)
						report_failure($sformatf("%0d payload bytes not received",
							exp_rx.size()));
					exp_rx.delete();
				end
			end
			if (rx_valid) begin
				if (exp_rx.size() == 0) begin
					report_mismatch($sformatf("unexpected rx byte %h", rx_data));
				end else begin
					exp_byte = exp_rx.pop_front();
					if (rx_data != exp_byte)
						report_mismatch($sformatf("rx_data %h, expected %h", rx_data,
							exp_byte));
				end
			end
			if (rx_error) begin
				if (exp_err == 0)
					report_mismatch("rx_error pulse without a bad packet");
				else
					exp_err--;
			end
			// Idle level of the current speed
			idle_cnt = txoe ? 0 : idle_cnt + 1;
			if (idle_cnt > 2 * bc + 2) begin
				idle_cnt = 0;
				if ((txp != !low_speed) || (txm != low_speed))
					report_mismatch($sformatf("idle line txp %b txm %b", txp, txm));
			end
			hold_cnt = generate_reset ? hold_cnt + 1 : 0;
			if ((hold_cnt > 2 * bc + 2) && !(txoe && !txp && !txm))
				report_mismatch("line left SE0 during bus reset");
			txoe_prev = txoe;
		end
	end

endmodule

/* build.f */
source/usb_phy_pkg.sv
source/usb_line_if.sv
source/usb_tx.sv
source/usb_rx_sampler.sv
source/usb_rx_decoder.sv
source/usb_phy.sv
bench/usb_phy_checker.sv
bench/tb_usb_phy.sv

/* source/usb_line_if.sv */
// ##########################################################################
// Sampled line state and bit timing from the receive sampler to the
// decoder. The sampler drives every signal.
// ##########################################################################

`timescale 1ns/1ps

interface usb_line_if;
	import usb_phy_pkg::*;

	// One cycle per bit, near mid-bit
	logic bit_strobe;
	// Line state valid together with bit_strobe
	line_state_t state;
	// Lock lost, no transition for seven bit times
	logic idle_reset;

	modport sampler (
		output bit_strobe,
		output state,
		output idle_reset
	);

	modport decoder (
		input bit_strobe,
		input state,
		input idle_reset
	);

endinterface

/* source/usb_phy.sv */
// ##########################################################################
// USB 1.1 PHY top level. Joins the transmitter to the receive sampler and
// decoder. The SIE connects to the byte ports, the transceiver to the line.
// ##########################################################################

`timescale 1ns/1ps

module usb_phy (
	input  logic                   usb_clk,
	input  logic                   usb_rst,
	input  usb_phy_pkg::usb_byte_t tx_data,
	input  logic                   tx_valid,
	output logic                   tx_ready,
	input  logic                   generate_eop,
	input  logic                   generate_reset,
	output logic                   txp,
	output logic                   txm,
	output logic                   txoe,
	input  logic                   rxp,
	input  logic                   rxm,
	input  logic                   low_speed,
	output usb_phy_pkg::usb_byte_t rx_data,
	output logic                   rx_valid,
	output logic                   rx_active,
	output logic                   rx_error
);

	// Sampler to decoder link
	usb_line_if line ();

	usb_tx u_tx (
		.usb_clk        (usb_clk),
		.usb_rst        (usb_rst),
		.tx_data        (tx_data),
		.tx_valid       (tx_valid),
		.tx_ready       (tx_ready),
		.generate_eop   (generate_eop),
		.generate_reset (generate_reset),
		.low_speed      (low_speed),
		.txp            (txp),
		.txm            (txm),
		.txoe           (txoe)
	);

	usb_rx_sampler u_rx_sampler (
		.usb_clk   (usb_clk),
		.usb_rst   (usb_rst),
		.rxp       (rxp),
		.rxm       (rxm),
		.low_speed (low_speed),
		.line      (line.sampler)
	);

	usb_rx_decoder u_rx_decoder (
		.usb_clk   (usb_clk),
		.usb_rst   (usb_rst),
		.line      (line.decoder),
		.rx_data   (rx_data),
		.rx_valid  (rx_valid),
		.rx_active (rx_active),
		.rx_error  (rx_error)
	);

endmodule

/* source/usb_phy_pkg.sv */
// ##########################################################################
// Shared constants and types for the USB 1.1 full/low speed PHY.
// Imported by the transmitter, both receiver stages and the line interface.
// ##########################################################################

package usb_phy_pkg;

	// One data byte on the transmit or receive side
	typedef logic [7:0] usb_byte_t;

	// usb_clk cycles per bit at 48 MHz
	localparam int FS_BIT_CLKS = 4;
	localparam int LS_BIT_CLKS = 32;

	// Ones in a row before a zero is stuffed
	localparam int STUFF_RUN = 6;

	// First byte of every packet, LSB first on the wire
	localparam usb_byte_t SYNC_BYTE = 8'h80;

	// Bit phase counter, wide enough for the slow rate
	localparam int PHASE_W = $clog2(LS_BIT_CLKS);
	typedef logic [PHASE_W-1:0] phase_t;

	// Decoded wire pair, J and K in the sense of the current speed
	typedef enum logic [1:0] {
		LINE_J,
		LINE_K,
		LINE_SE0,
		LINE_SE1
	} line_state_t;

	typedef enum logic [2:0] {
		TX_IDLE,
		TX_DATA,
		TX_EOP1,
		TX_EOP2,
		TX_J,
		TX_GEOP1,
		TX_GEOP2,
		TX_GJ
	} tx_state_t;

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_SYNC,
		RX_DATA,
		RX_EOP
	} rx_state_t;

endpackage

/* source/usb_rx_decoder.sv */
// ##########################################################################
// Receive bit decoder. Turns strobed line states into bytes: NRZI decode,
// zero removal, SYNC check, payload strobes and EOP with error report.
// ##########################################################################

`timescale 1ns/1ps

module usb_rx_decoder (
	input  logic                   usb_clk,
	input  logic                   usb_rst,
	usb_line_if.decoder            line,
	output usb_phy_pkg::usb_byte_t rx_data,
	output logic                   rx_valid,
	output logic                   rx_active,
	output logic                   rx_error
);
	import usb_phy_pkg::*;

	rx_state_t   state;
	line_state_t last_level;
	usb_byte_t   shreg;
	usb_byte_t   next_byte;
	logic [2:0]  bit_cnt;
	logic [2:0]  one_cnt;
	logic        err_pending;
	logic        level_bit;

	// No change since the previous bit decodes as a one
	assign level_bit = (line.state == last_level);
	assign next_byte = {level_bit, shreg[7:1]};

	always_ff @(posedge usb_clk) begin
		if (usb_rst) begin
			state       <= RX_IDLE;
			rx_valid    <= 1'b0;
			rx_active   <= 1'b0;
			rx_error    <= 1'b0;
			err_pending <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			rx_error <= 1'b0;
			if (line.idle_reset && (state != RX_IDLE)) begin
				// Lock lost inside a packet
				state       <= RX_IDLE;
				rx_active   <= 1'b0;
				rx_error    <= err_pending;
				err_pending <= 1'b0;
			end else if (line.bit_strobe) begin
				case (state)
					RX_IDLE: begin
						// First K is the first SYNC bit, a zero
						if (line.state == LINE_K) begin
							state       <= RX_SYNC;
							last_level  <= LINE_K;
							shreg       <= '0;
							bit_cnt     <= 3'd1;
							one_cnt     <= '0;
							err_pending <= 1'b0;
						end
					end
					RX_SYNC, RX_DATA: begin
						if (line.state == LINE_SE0) begin
							state <= RX_EOP;
							if ((bit_cnt != 3'd0) || (state == RX_SYNC))
								err_pending <= 1'b1;
						end else if (line.state == LINE_SE1) begin
							err_pending <= 1'b1;
						end else begin
							last_level <= line.state;
							if (one_cnt == 3'(STUFF_RUN)) begin
								// Stuffed bit dropped, a one here is an error
								one_cnt <= '0;
								if (level_bit)
									err_pending <= 1'b1;
							end else begin
								one_cnt <= level_bit ? one_cnt + 3'd1 : 3'd0;
								shreg   <= next_byte;
								bit_cnt <= bit_cnt + 3'd1;
								if (bit_cnt == 3'd7) begin
									if (state == RX_SYNC) begin
										state <= RX_DATA;
										if (next_byte == SYNC_BYTE)
											rx_active <= 1'b1;
										else
											err_pending <= 1'b1;
									end else begin
										rx_data  <= next_byte;
										rx_valid <= rx_active;
									end
								end
							end
						end
					end
					default: begin
						// Second EOP bit closes the packet
						state       <= RX_IDLE;
						rx_active   <= 1'b0;
						rx_error    <= err_pending || (line.state != LINE_SE0);
						err_pending <= 1'b0;
					end
				endcase
			end
		end
	end

	a_valid_active: assert property (@(posedge usb_clk) disable iff (usb_rst)
		rx_valid |-> rx_active);

endmodule

/* source/usb_rx_sampler.sv */
// ##########################################################################
// Receive front end. Synchronises rxp/rxm, decodes the line state and
// generates a mid-bit strobe locked to the last line transition.
// ##########################################################################

`timescale 1ns/1ps

module usb_rx_sampler (
	input  logic       usb_clk,
	input  logic       usb_rst,
	input  logic       rxp,
	input  logic       rxm,
	input  logic       low_speed,
	usb_line_if.sampler line
);
	import usb_phy_pkg::*;

	logic [1:0]  rx_meta;
	logic [1:0]  rx_sync;
	line_state_t cur_state;
	line_state_t prev_state;
	phase_t      phase;
	phase_t      half;
	phase_t      last;
	logic [3:0]  quiet_cnt;
	logic        changed;
	logic        strobe;

	// Two-flop synchroniser
	always_ff @(posedge usb_clk) begin
		rx_meta <= {rxp, rxm};
		rx_sync <= rx_meta;
	end

	// Low speed swaps J and K
	always_comb begin
		case (rx_sync)
			2'b10:   cur_state = low_speed ? LINE_K : LINE_J;
			2'b01:   cur_state = low_speed ? LINE_J : LINE_K;
			2'b00:   cur_state = LINE_SE0;
			default: cur_state = LINE_SE1;
		endcase
	end

	assign last    = low_speed ? phase_t'(LS_BIT_CLKS - 1) : phase_t'(FS_BIT_CLKS - 1);
	assign half    = low_speed ? phase_t'(LS_BIT_CLKS / 2) : phase_t'(FS_BIT_CLKS / 2);
	assign changed = (cur_state != prev_state);
	assign strobe  = !changed && (phase == half);

	always_ff @(posedge usb_clk) begin
		if (usb_rst) begin
			prev_state      <= LINE_J;
			phase           <= '0;
			quiet_cnt       <= '0;
			line.bit_strobe <= 1'b0;
			line.state      <= LINE_J;
		end else begin
			prev_state <= cur_state;
			// Transition cycle counts as phase zero
			if (changed)
				phase <= phase_t'(1);
			else if (phase == last)
				phase <= '0;
			else
				phase <= phase + phase_t'(1);
			// Strobes since the last transition, saturating
			if (changed)
				quiet_cnt <= '0;
			else if (strobe && !quiet_cnt[3])
				quiet_cnt <= quiet_cnt + 4'd1;
			line.bit_strobe <= strobe;
			line.state      <= cur_state;
		end
	end

	assign line.idle_reset = quiet_cnt[3];

endmodule

/* source/usb_tx.sv */
// ##########################################################################
// USB transmitter. Takes bytes over valid/ready, stuffs and NRZI-encodes
// them onto txp/txm/txoe and closes each packet with SE0, SE0, J.
// Also sends a standalone EOP on request and holds SE0 for bus reset.
// ##########################################################################

`timescale 1ns/1ps

module usb_tx (
	input  logic                  usb_clk,
	input  logic                  usb_rst,
	input  usb_phy_pkg::usb_byte_t tx_data,
	input  logic                  tx_valid,
	output logic                  tx_ready,
	input  logic                  generate_eop,
	input  logic                  generate_reset,
	input  logic                  low_speed,
	output logic                  txp,
	output logic                  txm,
	output logic                  txoe
);
	import usb_phy_pkg::*;

	logic      txp_r;
	logic      txm_r;
	logic      txoe_r;
	phase_t    gce_cnt;
	logic      gce;
	logic      sr_rst;
	logic      sr_load;
	logic      sr_done;
	logic      sr_out;
	logic [2:0] bit_cnt;
	logic [2:0] one_cnt;
	logic [6:0] sr;
	logic      txoe_ctl;
	logic      gen_se0;
	logic      gen_j;
	tx_state_t state;
	tx_state_t next_state;
	logic      tx_ready_d;
	logic      tx_valid_r;
	logic      tx_continue;
	logic      end_ack;
	logic      eop_pending;
	logic      eop_clear;

	// Second register stage on the line
	always_ff @(posedge usb_clk) begin
		if (usb_rst) begin
			txp  <= ~low_speed;
			txm  <= low_speed;
			txoe <= 1'b0;
		end else begin
			txp  <= txp_r;
			txm  <= txm_r;
			txoe <= txoe_r;
		end
	end

	// Bit enable, one pulse per bit time
	always_ff @(posedge usb_clk) begin
		if (usb_rst) begin
			gce_cnt <= '0;
			gce     <= 1'b0;
		end else begin
			gce_cnt <= gce_cnt + phase_t'(1);
			if (low_speed)
				gce <= (gce_cnt == phase_t'(LS_BIT_CLKS - 1));
			else
				gce <= ((gce_cnt & phase_t'(FS_BIT_CLKS - 1)) == phase_t'(FS_BIT_CLKS - 1));
		end
	end

	// Serializer with zero insertion, the ones count spans bytes
	always_ff @(posedge usb_clk) begin
		if (usb_rst || sr_rst) begin
			sr_done <= 1'b1;
			one_cnt <= '0;
		end else if (gce) begin
			if (sr_load) begin
				sr_done <= 1'b0;
				sr_out  <= tx_data[0];
				bit_cnt <= '0;
				one_cnt <= tx_data[0] ? one_cnt + 3'd1 : 3'd0;
				sr      <= tx_data[7:1];
			end else if (!sr_done) begin
				if (one_cnt == 3'(STUFF_RUN)) begin
					// Stuffed zero, payload bit waits
					one_cnt <= '0;
					sr_out  <= 1'b0;
					if (bit_cnt == 3'd7)
						sr_done <= 1'b1;
				end else begin
					sr_out  <= sr[0];
					one_cnt <= sr[0] ? one_cnt + 3'd1 : 3'd0;
					bit_cnt <= bit_cnt + 3'd1;
					// Last bit, unless it completes a run needing a stuff
					if ((bit_cnt == 3'd6) && (!sr[0] || (one_cnt != 3'(STUFF_RUN - 1))))
						sr_done <= 1'b1;
					sr <= {1'b0, sr[6:1]};
				end
			end
		end
	end

	// Line encoder, a zero bit toggles the pair
	always_ff @(posedge usb_clk) begin
		if (usb_rst) begin
			txoe_r <= 1'b0;
			txp_r  <= ~low_speed;
			txm_r  <= low_speed;
		end else if (gce) begin
			txoe_r <= txoe_ctl;
			if (!txoe_ctl || gen_j) begin
				txp_r <= ~low_speed;
				txm_r <= low_speed;
			end else if (generate_reset || gen_se0) begin
				txp_r <= 1'b0;
				txm_r <= 1'b0;
			end else if (!sr_out) begin
				txp_r <= ~txp_r;
				txm_r <= ~txm_r;
			end
		end
	end

	always_ff @(posedge usb_clk) begin
		if (usb_rst) begin
			state       <= TX_IDLE;
			tx_ready    <= 1'b0;
			tx_valid_r  <= 1'b0;
			tx_continue <= 1'b1;
			eop_pending <= 1'b0;
		end else begin
			if (gce)
				state <= next_state;
			tx_ready   <= tx_ready_d && gce;
			tx_valid_r <= tx_valid;
			// Falling tx_valid ends the packet after the current byte
			if (tx_valid_r && !tx_valid)
				tx_continue <= 1'b0;
			if (end_ack)
				tx_continue <= 1'b1;
			if (generate_eop)
				eop_pending <= 1'b1;
			if (eop_clear)
				eop_pending <= 1'b0;
		end
	end

	always_comb begin
		next_state = state;
		txoe_ctl   = 1'b1;
		sr_rst     = 1'b1;
		sr_load    = 1'b0;
		gen_se0    = 1'b0;
		gen_j      = 1'b0;
		tx_ready_d = 1'b0;
		end_ack    = 1'b0;
		eop_clear  = 1'b0;
		case (state)
			TX_IDLE: begin
				txoe_ctl = generate_reset;
				if (eop_pending) begin
					next_state = TX_GEOP1;
				end else begin
					tx_ready_d = 1'b1;
					if (tx_valid) begin
						sr_rst     = 1'b0;
						sr_load    = 1'b1;
						next_state = TX_DATA;
					end
				end
			end
			TX_DATA: begin
				sr_rst = 1'b0;
				if (sr_done) begin
					if (tx_continue) begin
						sr_load    = 1'b1;
						tx_ready_d = 1'b1;
					end else begin
						next_state = TX_EOP1;
					end
				end
			end
			TX_EOP1: begin
				end_ack    = 1'b1;
				gen_se0    = 1'b1;
				next_state = TX_EOP2;
			end
			TX_EOP2: begin
				gen_se0    = 1'b1;
				next_state = TX_J;
			end
			TX_J: begin
				gen_j      = 1'b1;
				next_state = TX_IDLE;
			end
			TX_GEOP1: begin
				gen_se0    = 1'b1;
				next_state = TX_GEOP2;
			end
			TX_GEOP2: begin
				gen_se0    = 1'b1;
				next_state = TX_GJ;
			end
			default: begin
				eop_clear  = 1'b1;
				gen_j      = 1'b1;
				next_state = TX_IDLE;
			end
		endcase
	end

	a_ready_state: assert property (@(posedge usb_clk) disable iff (usb_rst)
		tx_ready |-> (state inside {TX_IDLE, TX_DATA}));

	a_no_se1: assert property (@(posedge usb_clk) disable iff (usb_rst)
		txoe |-> !(txp && txm));

endmodule
